// File: verilog/pcs_geom_pkg.sv
// Word geometry of the two-lane 8b/10b transmit encoder
// Lane count, byte and symbol widths, and the vector types built on them
// Lane 1 sits in the upper bits of each word and is sent first

package pcs_geom_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Byte lanes per word
  localparam int NUM_LANES = 2;

  // Unencoded byte and encoded symbol
  localparam int BYTE_W = 8;
  localparam int SYM_W  = 10;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  // One byte before encoding, HGF EDCBA
  typedef logic [BYTE_W-1:0] byte_t;

  // One symbol, abcdei fghj with a in bit 9 and j in bit 0
  typedef logic [SYM_W-1:0] sym10_t;

  // Input word, lane i in bits i*8 +: 8
  typedef logic [NUM_LANES*BYTE_W-1:0] data_word_t;

  // Output word, lane i in bits i*10 +: 10
  typedef logic [NUM_LANES*SYM_W-1:0] enc_word_t;

  // One flag per lane
  typedef logic [NUM_LANES-1:0] lane_bits_t;

endpackage

// File: verilog/pcs_code_pkg.sv
// 8b/10b code definitions shared by the decode and encode stages
// Running disparity type and the control codes that may be sent
// A control byte is valid when it is K28.y or Kx.7 with x in K_LOW5_OK

package pcs_code_pkg;

  ////////////////////////////////////////
  // Running disparity
  ////////////////////////////////////////

  // RD_NEG is the state after reset
  typedef enum logic
  {
    RD_NEG = 1'b0,
    RD_POS = 1'b1
  } rd_e;

  ////////////////////////////////////////
  // Control codes
  ////////////////////////////////////////

  // Low five bits of the K28 family
  // All eight values of the high three bits are allowed here
  localparam logic [4:0] K28_X = 5'd28;

  // High three bits needed by the other control codes
  localparam logic [2:0] K_D7_SET = 3'd7;

  // Low five bits allowed together with K_D7_SET
  // K23.7, K27.7, K29.7 and K30.7
  localparam int K_LOW5_NUM = 4;

  localparam logic [4:0] K_LOW5_OK [K_LOW5_NUM] = '{
    5'd23,
    5'd27,
    5'd29,
    5'd30
  };

  // These controls always take the alternate fghj form
  // The 6b part comes from the data table

endpackage

// File: verilog/enc_lane_code.sv
// 8b/10b encoder for one byte, purely combinational
// 5b/6b and 3b/4b tables after IEEE 802.3 clause 36
// rd_in is the disparity before the symbol, rd_out the one after it
`timescale 1ns/1ps

module enc_lane_code (
  input  pcs_geom_pkg::byte_t  din,
  input  logic                 kin,
  input  pcs_code_pkg::rd_e    rd_in,
  output pcs_geom_pkg::sym10_t sym,
  output pcs_code_pkg::rd_e    rd_out
);

  import pcs_geom_pkg::*;
  import pcs_code_pkg::*;

  logic [4:0] x;
  logic [2:0] y;
  logic       k28;
  logic [5:0] raw6;
  logic [5:0] code6;
  logic [3:0] raw4;
  logic [3:0] code4;
  logic       use_a7;
  rd_e        rd_mid;

  assign x   = din[4:0];
  assign y   = din[7:5];
  assign k28 = kin && (x == K28_X);

  ////////////////////////////////////////
  // 5b/6b sub-block
  ////////////////////////////////////////

  // Table holds the RD- form, abcdei
  always_comb
  begin
    case (x)
      5'd0:    raw6 = 6'b100111;
      5'd1:    raw6 = 6'b011101;
      5'd2:    raw6 = 6'b101101;
      5'd3:    raw6 = 6'b110001;
      5'd4:    raw6 = 6'b110101;
      5'd5:    raw6 = 6'b101001;
      5'd6:    raw6 = 6'b011001;
      5'd7:    raw6 = 6'b111000;
      5'd8:    raw6 = 6'b111001;
      5'd9:    raw6 = 6'b100101;
      5'd10:   raw6 = 6'b010101;
      5'd11:   raw6 = 6'b110100;
      5'd12:   raw6 = 6'b001101;
      5'd13:   raw6 = 6'b101100;
      5'd14:   raw6 = 6'b011100;
      5'd15:   raw6 = 6'b010111;
      5'd16:   raw6 = 6'b011011;
      5'd17:   raw6 = 6'b100011;
      5'd18:   raw6 = 6'b010011;
      5'd19:   raw6 = 6'b110010;
      5'd20:   raw6 = 6'b001011;
      5'd21:   raw6 = 6'b101010;
      5'd22:   raw6 = 6'b011010;
      5'd23:   raw6 = 6'b111010;
      5'd24:   raw6 = 6'b110011;
      5'd25:   raw6 = 6'b100110;
      5'd26:   raw6 = 6'b010110;
      5'd27:   raw6 = 6'b110110;
      5'd28:   raw6 = k28 ? 6'b001111 : 6'b001110;
      5'd29:   raw6 = 6'b101110;
      5'd30:   raw6 = 6'b011110;
      default: raw6 = 6'b101011;
    endcase

    // Unbalanced codes and D.7 invert at positive disparity
    if (rd_in == RD_POS && ($countones(raw6) != 3 || x == 5'd7))
    begin
      code6 = ~raw6;
    end
    else
    begin
      code6 = raw6;
    end
  end

  // Disparity between the two sub-blocks
  assign rd_mid = ($countones(code6) > 3) ? RD_POS :
                  ($countones(code6) < 3) ? RD_NEG : rd_in;

  ////////////////////////////////////////
  // 3b/4b sub-block
  ////////////////////////////////////////

  // Alternate .7 form avoids a run of five equal bits
  assign use_a7 = kin ||
                  (rd_mid == RD_NEG && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                  (rd_mid == RD_POS && (x == 5'd11 || x == 5'd13 || x == 5'd14));

  always_comb
  begin
    case (y)
      3'd0:    raw4 = 4'b1011;
      3'd1:    raw4 = 4'b1001;
      3'd2:    raw4 = 4'b0101;
      3'd3:    raw4 = 4'b1100;
      3'd4:    raw4 = 4'b1101;
      3'd5:    raw4 = 4'b1010;
      3'd6:    raw4 = 4'b0110;
      default: raw4 = use_a7 ? 4'b0111 : 4'b1110;
    endcase

    // K28 turns the neutral codes around
    if (k28 && (y == 3'd1 || y == 3'd2 || y == 3'd5 || y == 3'd6))
    begin
      raw4 = ~raw4;
    end

    if (rd_mid == RD_POS && ($countones(raw4) != 2 || y == 3'd3 || k28))
    begin
      code4 = ~raw4;
    end
    else
    begin
      code4 = raw4;
    end
  end

  assign sym    = {code6, code4};
  assign rd_out = ($countones(code4) > 2) ? RD_POS :
                  ($countones(code4) < 2) ? RD_NEG : rd_mid;

endmodule

// File: verilog/enc_decode.sv
// Input stage of the transmit encoder
// Registers the data word, the K flags and the disparity controls
// A K request that is not one of the twelve control codes is dropped
// and reported on lane_bad_k, the byte then goes out as data
`timescale 1ns/1ps

module enc_decode (
  input  logic                                                    CLK_IN,
  input  logic                                                    aresetn,
  input  pcs_geom_pkg::data_word_t                                data,
  input  pcs_geom_pkg::lane_bits_t                                k,
  input  pcs_geom_pkg::lane_bits_t                                force_disp,
  input  pcs_geom_pkg::lane_bits_t                                disp_sel,
  output pcs_geom_pkg::byte_t [pcs_geom_pkg::NUM_LANES-1:0]       lane_byte,
  output pcs_geom_pkg::lane_bits_t                                lane_k,
  output pcs_geom_pkg::lane_bits_t                                lane_bad_k,
  output pcs_geom_pkg::lane_bits_t                                lane_force,
  output pcs_geom_pkg::lane_bits_t                                lane_sel
);

  import pcs_geom_pkg::*;
  import pcs_code_pkg::*;

  // Lane byte may be sent as a control code
  lane_bits_t k_ok;

  function automatic logic k_code_ok(input byte_t b);
    logic ok;
    ok = (b[4:0] == K28_X);
    for (int j = 0; j < K_LOW5_NUM; j++)
    begin
      if (b[7:5] == K_D7_SET && b[4:0] == K_LOW5_OK[j])
      begin
        ok = 1'b1;
      end
    end
    return ok;
  endfunction

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      k_ok[i] = k_code_ok(data[i*BYTE_W +: BYTE_W]);
    end
  end

  ////////////////////////////////////////
  // Input register
  ////////////////////////////////////////

  always_ff @(posedge CLK_IN or negedge aresetn)
  begin
    if (!aresetn)
    begin
      lane_byte  <= '0;
      lane_k     <= '0;
      lane_bad_k <= '0;
      lane_force <= '0;
      lane_sel   <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
        lane_byte[i] <= data[i*BYTE_W +: BYTE_W];
      end
      lane_k     <= k & k_ok;
      lane_bad_k <= k & ~k_ok;
      lane_force <= force_disp;
      lane_sel   <= disp_sel;
    end
  end

endmodule

// File: verilog/enc_execute.sv
// Encode stage of the transmit encoder
// Chains the running disparity from lane 1 down to lane 0 in one cycle
// A forced lane restarts the chain from its select bit
// Holds the running disparity and the output registers
`timescale 1ns/1ps

module enc_execute (
  input  logic                                                    CLK_IN,
  input  logic                                                    aresetn,
  input  pcs_geom_pkg::byte_t [pcs_geom_pkg::NUM_LANES-1:0]       lane_byte,
  input  pcs_geom_pkg::lane_bits_t                                lane_k,
  input  pcs_geom_pkg::lane_bits_t                                lane_bad_k,
  input  pcs_geom_pkg::lane_bits_t                                lane_force,
  input  pcs_geom_pkg::lane_bits_t                                lane_sel,
  output pcs_geom_pkg::enc_word_t                                 enc_out,
  output pcs_geom_pkg::lane_bits_t                                invalid_k
);

  import pcs_geom_pkg::*;
  import pcs_code_pkg::*;

  // Running disparity carried between words
  rd_e    rd_q;
  rd_e    lane_rd_in  [NUM_LANES];
  rd_e    lane_rd_out [NUM_LANES];
  sym10_t lane_sym    [NUM_LANES];

  ////////////////////////////////////////
  // Lane encoders and disparity chain
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_lane
    rd_e chain_rd;

    // Top lane is sent first and continues the previous word
    if (i == NUM_LANES - 1)
    begin : g_first
      assign chain_rd = rd_q;
    end
    else
    begin : g_next
      assign chain_rd = lane_rd_out[i+1];
    end

    assign lane_rd_in[i] = lane_force[i] ? rd_e'(lane_sel[i]) : chain_rd;

    enc_lane_code u_code (
      .din    (lane_byte[i]),
      .kin    (lane_k[i]),
      .rd_in  (lane_rd_in[i]),
      .sym    (lane_sym[i]),
      .rd_out (lane_rd_out[i])
    );
  end

  ////////////////////////////////////////
  // Output and disparity registers
  ////////////////////////////////////////

  always_ff @(posedge CLK_IN or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rd_q      <= RD_NEG;
      enc_out   <= '0;
      invalid_k <= '0;
    end
    else
    begin
      rd_q <= lane_rd_out[0];
      for (int i = 0; i < NUM_LANES; i++)
      begin
        enc_out[i*SYM_W +: SYM_W] <= lane_sym[i];
      end
      invalid_k <= lane_bad_k;
    end
  end

  // Each symbol sent after reset is within two of balance
  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_chk
    a_sym_weight: assert property (@(posedge CLK_IN) disable iff (!aresetn)
      $past(aresetn) |-> ($countones(enc_out[i*SYM_W +: SYM_W]) >= 4 &&
                          $countones(enc_out[i*SYM_W +: SYM_W]) <= 6));
  end

endmodule

// File: verilog/pcs_encoder.sv
// Two-lane 8b/10b transmit encoder, top level
// One 16-bit word with per-byte K flags goes in every clock
// The 20-bit encoded word comes out two clocks later
`timescale 1ns/1ps

module pcs_encoder (
  input  logic                     CLK_IN,
  input  logic                     aresetn,
  input  pcs_geom_pkg::data_word_t data,
  input  pcs_geom_pkg::lane_bits_t k,
  input  pcs_geom_pkg::lane_bits_t force_disp,
  input  pcs_geom_pkg::lane_bits_t disp_sel,
  output pcs_geom_pkg::enc_word_t  enc_out,
  output pcs_geom_pkg::lane_bits_t invalid_k
);

  import pcs_geom_pkg::*;

  // Decode to execute
  byte_t [NUM_LANES-1:0] lane_byte;
  lane_bits_t            lane_k;
  lane_bits_t            lane_bad_k;
  lane_bits_t            lane_force;
  lane_bits_t            lane_sel;

  enc_decode u_decode (
    .CLK_IN     (CLK_IN),
    .aresetn    (aresetn),
    .data       (data),
    .k          (k),
    .force_disp (force_disp),
    .disp_sel   (disp_sel),
    .lane_byte  (lane_byte),
    .lane_k     (lane_k),
    .lane_bad_k (lane_bad_k),
    .lane_force (lane_force),
    .lane_sel   (lane_sel)
  );

  enc_execute u_execute (
    .CLK_IN     (CLK_IN),
    .aresetn    (aresetn),
    .lane_byte  (lane_byte),
    .lane_k     (lane_k),
    .lane_bad_k (lane_bad_k),
    .lane_force (lane_force),
    .lane_sel   (lane_sel),
    .enc_out    (enc_out),
    .invalid_k  (invalid_k)
  );

endmodule

// File: verif/tb_ref.svh
// Reference model of the two-lane 8b/10b encoder for the testbench
// Included inside the testbench module after the package imports
// encode_word encodes one word from a starting disparity and returns the next one
`ifndef TB_REF_SVH
`define TB_REF_SVH

// K28.0 to K28.7, then K23.7 K27.7 K29.7 K30.7
localparam int K_COUNT = 12;
localparam byte_t K_TABLE [K_COUNT] = '{
  8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC, 8'hDC, 8'hFC,
  8'hF7, 8'hFB, 8'hFD, 8'hFE
};

// abcdei at negative disparity, indexed by EDCBA
localparam logic [5:0] SIX_NEG [32] = '{
  6'b100111, 6'b011101, 6'b101101, 6'b110001,
  6'b110101, 6'b101001, 6'b011001, 6'b111000,
  6'b111001, 6'b100101, 6'b010101, 6'b110100,
  6'b001101, 6'b101100, 6'b011100, 6'b010111,
  6'b011011, 6'b100011, 6'b010011, 6'b110010,
  6'b001011, 6'b101010, 6'b011010, 6'b111010,
  6'b110011, 6'b100110, 6'b010110, 6'b110110,
  6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// fghj indexed by HGF, chosen by the disparity after the 6b block
localparam logic [3:0] FOUR_D_NEG [8] = '{4'hB, 4'h9, 4'h5, 4'hC, 4'hD, 4'hA, 4'h6, 4'hE};
localparam logic [3:0] FOUR_D_POS [8] = '{4'h4, 4'h9, 4'h5, 4'h3, 4'h2, 4'hA, 4'h6, 4'h1};
localparam logic [3:0] FOUR_K_NEG [8] = '{4'hB, 4'h6, 4'hA, 4'hC, 4'hD, 4'h5, 4'h9, 4'h7};
localparam logic [3:0] FOUR_K_POS [8] = '{4'h4, 4'h9, 4'h5, 4'h3, 4'h2, 4'hA, 4'h6, 4'h8};

function automatic logic is_k_code(input byte_t b);
  logic hit;
  hit = 1'b0;
  for (int i = 0; i < K_COUNT; i++)
  begin
    if (K_TABLE[i] == b)
      hit = 1'b1;
  end
  return hit;
endfunction

// Disparity after a sub-block of the given size
function automatic rd_e block_rd(input int ones, input int size, input rd_e rd);
  if (2 * ones > size)
    return RD_POS;
  if (2 * ones < size)
    return RD_NEG;
  return rd;
endfunction

function automatic sym10_t encode_byte(input byte_t b, input logic is_k, input rd_e rd_in,
                                       output rd_e rd_out);
  logic [4:0] x;
  logic [2:0] y;
  logic [5:0] six;
  logic [3:0] four;
  rd_e        rd_mid;
  x = b[4:0];
  y = b[7:5];
  six = (is_k && x == 5'd28) ? 6'b001111 : SIX_NEG[x];
  // Unbalanced codes and the D.7 pair flip at positive disparity
  if (rd_in == RD_POS && ($countones(six) != 3 || x == 5'd7))
    six = ~six;
  rd_mid = block_rd($countones(six), 6, rd_in);
  if (is_k && x == 5'd28)
    four = (rd_mid == RD_NEG) ? FOUR_K_NEG[y] : FOUR_K_POS[y];
  else if (y == 3'd7 && (is_k || (rd_mid == RD_NEG && x inside {5'd17, 5'd18, 5'd20}) ||
                         (rd_mid == RD_POS && x inside {5'd11, 5'd13, 5'd14})))
    four = (rd_mid == RD_NEG) ? 4'b0111 : 4'b1000;
  else
    four = (rd_mid == RD_NEG) ? FOUR_D_NEG[y] : FOUR_D_POS[y];
  rd_out = block_rd($countones(four), 4, rd_mid);
  return {six, four};
endfunction

// Lane 1 first, a forced lane starts from its select bit
function automatic void encode_word(input data_word_t d, input lane_bits_t kreq,
                                    input lane_bits_t fd, input lane_bits_t ds,
                                    input rd_e rd_start, output rd_e rd_end,
                                    output enc_word_t enc, output lane_bits_t bad);
  rd_e   rd;
  rd_e   rd_next;
  byte_t b;
  logic  kv;
  rd = rd_start;
  for (int lane = NUM_LANES - 1; lane >= 0; lane--)
  begin
    b = d[lane*BYTE_W +: BYTE_W];
    kv = is_k_code(b);
    bad[lane] = kreq[lane] && !kv;
    if (fd[lane])
      rd = ds[lane] ? RD_POS : RD_NEG;
    enc[lane*SYM_W +: SYM_W] = encode_byte(b, kreq[lane] && kv, rd, rd_next);
    rd = rd_next;
  end
  rd_end = rd;
endfunction

`endif

// File: verif/tb_pcs_encoder.sv
// Testbench for the two-lane 8b/10b transmit encoder
// Drives random and directed words on the falling edge and checks each
// output word against encode_word from tb_ref.svh
`timescale 1ns/1ps

module tb_pcs_encoder;

  import pcs_geom_pkg::*;
  import pcs_code_pkg::*;

  `include "tb_ref.svh"

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 2;
  localparam int PIPE_DEPTH   = 2;
  localparam int N_RANDOM     = 200;
  localparam int N_CTRL       = K_COUNT * 5;
  localparam int N_BAD_K      = 40;
  localparam int N_FORCE      = 80;
  localparam int N_WORDS      = RESET_CYCLES + N_RANDOM + N_CTRL + N_BAD_K + N_FORCE + 3;
  // Twice the stimulus length
  localparam int TIMEOUT_NS   = 2 * N_WORDS * 2 * HALF_PERIOD;

  typedef struct packed
  {
    data_word_t d;
    lane_bits_t k;
    lane_bits_t f;
    lane_bits_t s;
  } stim_word_t;

  logic        CLK_IN;
  logic        aresetn;
  data_word_t  data;
  lane_bits_t  k;
  lane_bits_t  force_disp;
  lane_bits_t  disp_sel;
  enc_word_t   enc_out;
  lane_bits_t  invalid_k;
  string       test_name;
  int          errors;
  rd_e         seen_rd;

  // Words inside the DUT, oldest first
  stim_word_t  in_flight [$];
  string       flight_name [$];

  pcs_encoder dut_i (
    .CLK_IN     (CLK_IN),
    .aresetn    (aresetn),
    .data       (data),
    .k          (k),
    .force_disp (force_disp),
    .disp_sel   (disp_sel),
    .enc_out    (enc_out),
    .invalid_k  (invalid_k)
  );

  always #HALF_PERIOD CLK_IN = ~CLK_IN;

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_enc(input string name, input enc_word_t exp, input enc_word_t act);
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: enc_out expected %05h, actual %05h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bad_k(input string name, input lane_bits_t exp, input lane_bits_t act);
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: invalid_k expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // Follows the disparity of the sent symbols, restarted where a lane is forced
  task automatic verify_disparity(input string name, input enc_word_t act,
                                  input lane_bits_t fd, input lane_bits_t ds);
    sym10_t s;
    int     ones;
    int     size;
    int     diff;
    for (int lane = NUM_LANES - 1; lane >= 0; lane--)
    begin
      s = act[lane*SYM_W +: SYM_W];
      if (fd[lane])
        seen_rd = rd_e'(ds[lane]);
      for (int part = 0; part < 2; part++)
      begin
        ones = (part == 0) ? $countones(s[9:4]) : $countones(s[3:0]);
        size = (part == 0) ? 6 : 4;
        diff = 2 * ones - size;
        if (diff > 2 || diff < -2 || $countones(s) < 4 || $countones(s) > 6 ||
            (diff > 0 && seen_rd == RD_POS) || (diff < 0 && seen_rd == RD_NEG))
        begin
          errors++;
          $display("Test %s: lane %0d sent symbol %03h, which breaks the disparity rules",
                   name, lane, s);
          abort_run();
        end
        seen_rd = block_rd(ones, size, seen_rd);
      end
    end
  endtask

  task automatic drive(input string name, input data_word_t d, input lane_bits_t kf,
                       input lane_bits_t fd, input lane_bits_t ds);
    @(negedge CLK_IN);
    test_name  = name;
    data       = d;
    k          = kf;
    force_disp = fd;
    disp_sel   = ds;
  endtask

  function automatic byte_t random_non_k();
    byte_t b;
    b = byte_t'($urandom);
    while (is_k_code(b))
      b = byte_t'($urandom);
    return b;
  endfunction

  ////////////////////////////////////////
  // Output comparison
  ////////////////////////////////////////

  initial
  begin : compare_outputs
    stim_word_t w;
    string      name;
    enc_word_t  exp_enc;
    lane_bits_t exp_bad;
    rd_e        ref_rd;
    rd_e        rd_next;
    forever
    begin
      @(posedge CLK_IN);
      if (!aresetn)
      begin
        // Decode register holds a zero word out of reset
        ref_rd  = RD_NEG;
        seen_rd = RD_NEG;
        in_flight.delete();
        flight_name.delete();
        in_flight.push_back('0);
        flight_name.push_back("reset");
      end
      else
      begin
        in_flight.push_back(stim_word_t'({data, k, force_disp, disp_sel}));
        flight_name.push_back(test_name);
      end
      @(negedge CLK_IN);
      if (in_flight.size() < PIPE_DEPTH)
      begin
        check_enc("reset_idle", '0, enc_out);
        check_bad_k("reset_idle", '0, invalid_k);
      end
      else
      begin
        w    = in_flight.pop_front();
        name = flight_name.pop_front();
        encode_word(w.d, w.k, w.f, w.s, ref_rd, rd_next, exp_enc, exp_bad);
        ref_rd = rd_next;
        check_enc(name, exp_enc, enc_out);
        check_bad_k(name, exp_bad, invalid_k);
        verify_disparity(name, enc_out, w.f, w.s);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial
  begin : run_tests
    data_word_t d;
    lane_bits_t kf;
    CLK_IN     = 1'b0;
    aresetn    = 1'b0;
    data       = '0;
    k          = '0;
    force_disp = '0;
    disp_sel   = '0;
    test_name  = "reset";
    errors     = 0;
    void'($urandom(12607));
    repeat (RESET_CYCLES) @(negedge CLK_IN);
    aresetn = 1'b1;

    // Data only, the chain runs freely from word to word
    repeat (N_RANDOM)
      drive("random_data", data_word_t'($urandom), '0, '0, '0);

    // Each control code in each lane from both disparities, then in both lanes
    for (int c = 0; c < K_COUNT; c++)
    begin
      for (int lane = 0; lane < NUM_LANES; lane++)
      begin
        for (int pos = 0; pos < 2; pos++)
        begin
          d  = (lane == 1) ? {K_TABLE[c], byte_t'($urandom)} : {byte_t'($urandom), K_TABLE[c]};
          kf = (lane == 1) ? 2'b10 : 2'b01;
          drive("control_codes", d, kf, kf, (pos == 1) ? kf : '0);
        end
      end
      drive("control_codes", {K_TABLE[c], K_TABLE[c]}, '1, '0, '0);
    end

    // Rejected K requests go out as data
    repeat (N_BAD_K)
    begin
      kf = ($urandom % 2 == 1) ? 2'b10 : 2'b01;
      drive("bad_k", {random_non_k(), random_non_k()}, kf, '0, '0);
    end

    repeat (N_FORCE)
      drive("force_disp", data_word_t'($urandom), '0, lane_bits_t'($urandom),
            lane_bits_t'($urandom));

    repeat (PIPE_DEPTH + 1)
      drive("flush", '0, '0, '0, '0);
    @(posedge CLK_IN);
    if (errors == 0)
    begin
      $display("Simulation completed successfully");
      $finish;
    end
    else
    begin
      abort_run();
    end
  end

  initial
  begin : watchdog
    #(TIMEOUT_NS);
    $display("Watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
    abort_run();
  end

endmodule

// File: project.f
+incdir+verif
verilog/pcs_geom_pkg.sv
verilog/pcs_code_pkg.sv
verilog/enc_lane_code.sv
verilog/enc_decode.sv
verilog/enc_execute.sv
verilog/pcs_encoder.sv
verif/tb_pcs_encoder.sv

// File: Makefile
# Verilator build and run of the encoder testbench
# The run passes only when the log holds the pass message

VERILATOR ?= verilator
TOP       ?= tb_pcs_encoder
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
